/* turf_pkg.sv */
`default_nettype none

package turf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and link geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W       = 28;
    localparam int DATA_W       = 32;
    localparam int SPACE_W      = 15;
    localparam int CRATE_ADDR_W = 27;
    localparam int NUM_LINKS    = 4;
    localparam int LINK_W       = 2;

    // Targets of the register interconnect
    typedef enum logic [1:0] {
        SPACE_ID,
        SPACE_CRATE,
        SPACE_EMPTY
    } space_t;

    // Bridge kind field of the bridge control register
    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_kind_t;

    ////////////////////////////////////////////////////////////////////////////
    // ID space registers
    ////////////////////////////////////////////////////////////////////////////

    // Word offsets taken from byte address bits 14:2
    localparam logic [SPACE_W-3:0] REG_IDENT       = 13'd0;
    localparam logic [SPACE_W-3:0] REG_DATEVERSION = 13'd1;
    localparam logic [SPACE_W-3:0] REG_BRIDGE_CTRL = 13'd2;
    localparam logic [SPACE_W-3:0] REG_BRIDGE_STAT = 13'd3;

    localparam logic [DATA_W-1:0] IDENT_WORD = "TURF";
    // Rev B flag, 15-bit build date field, major/minor/revision
    localparam logic [DATA_W-1:0] DATEVERSION_WORD = {1'b1, 15'h0000, 4'd0, 4'd1, 8'd6};

    ////////////////////////////////////////////////////////////////////////////
    // Crate bridge
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [DATA_W-1:0] BRIDGE_ERR_DATA = 32'hFFFF_FFFF;
    localparam int BRIDGE_TIMEOUT_CYCLES = 256;
    // Write flag position in the address beat
    localparam int CMD_WE_BIT = 31;

    // Serial debug 16x ticks from the 100 MHz clock
    // 82/1024 gives 8 MHz within 0.1%, 25/4096 gives 38400 baud x16
    localparam int HSK_ACC_W = 10;
    localparam logic [HSK_ACC_W-1:0] HSK_ADD = 10'd82;
    localparam int GPS_ACC_W = 12;
    localparam logic [GPS_ACC_W-1:0] GPS_ADD = 12'd25;

endpackage

`default_nettype wire

/* turf_intercon.sv */
`timescale 1ns/1ns
`default_nettype none

module turf_intercon (
    input  wire                            ps_clk,
    input  wire                            rst_n_i,
    input  wire                            wb_cyc_i,
    input  wire                            wb_stb_i,
    input  wire                            wb_we_i,
    input  wire [turf_pkg::ADDR_W-1:0]     wb_adr_i,
    input  wire [turf_pkg::DATA_W-1:0]     wb_dat_i,
    output logic                           wb_ack_o,
    output logic [turf_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                           id_stb_o,
    output logic                           crate_stb_o,
    output logic                           slv_we_o,
    output logic [turf_pkg::CRATE_ADDR_W-1:0] slv_adr_o,
    output logic [turf_pkg::DATA_W-1:0]    slv_dat_o,
    input  wire                            id_ack_i,
    input  wire                            crate_ack_i,
    input  wire [turf_pkg::DATA_W-1:0]     id_dat_i,
    input  wire [turf_pkg::DATA_W-1:0]     crate_dat_i
);

    import turf_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SLAVE_WAIT,
        ACK
    } ic_state_t;

    ic_state_t state;
    space_t    space_d;
    space_t    space_q;
    logic [DATA_W-1:0] rdata_q;

    // Crate space takes the whole upper half
    always_comb begin
        if (wb_adr_i[27]) begin
            space_d = SPACE_CRATE;
        end else if (wb_adr_i[16:15] == 2'b00) begin
            space_d = SPACE_ID;
        end else begin
            space_d = SPACE_EMPTY;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state   <= IDLE;
            space_q <= SPACE_EMPTY;
        end else begin
            case (state)
                IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        space_q <= space_d;
                        state   <= SLAVE_WAIT;
                    end
                end
                SLAVE_WAIT: begin
                    // Empty space answers on its own one cycle in
                    if ((space_q == SPACE_EMPTY) ||
                        (space_q == SPACE_ID && id_ack_i) ||
                        (space_q == SPACE_CRATE && crate_ack_i)) begin
                        state <= ACK;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request and read data latches
    always_ff @(posedge ps_clk) begin
        if (state == IDLE && wb_cyc_i && wb_stb_i) begin
            slv_we_o  <= wb_we_i;
            slv_adr_o <= wb_adr_i[CRATE_ADDR_W-1:0];
            slv_dat_o <= wb_dat_i;
        end
        if (state == SLAVE_WAIT) begin
            case (space_q)
                SPACE_ID:    rdata_q <= id_dat_i;
                SPACE_CRATE: rdata_q <= crate_dat_i;
                default:     rdata_q <= '0;
            endcase
        end
    end

    assign id_stb_o    = (state == SLAVE_WAIT) && (space_q == SPACE_ID);
    assign crate_stb_o = (state == SLAVE_WAIT) && (space_q == SPACE_CRATE);
    assign wb_ack_o    = (state == ACK);
    assign wb_dat_o    = rdata_q;

    // One access at a time, so the master never sees back-to-back acks
    a_single_ack : assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

/* turf_id_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module turf_id_ctrl (
    input  wire                            ps_clk,
    input  wire                            rst_n_i,
    input  wire                            stb_i,
    input  wire                            we_i,
    input  wire [turf_pkg::SPACE_W-1:0]    adr_i,
    input  wire [turf_pkg::DATA_W-1:0]     dat_i,
    output logic                           ack_o,
    output logic [turf_pkg::DATA_W-1:0]    dat_o,
    output logic [turf_pkg::LINK_W-1:0]    bridge_link_o,
    output turf_pkg::bridge_kind_t         bridge_kind_o,
    input  wire [turf_pkg::NUM_LINKS-1:0]  timeout_i,
    input  wire [turf_pkg::NUM_LINKS-1:0]  invalid_i
);

    import turf_pkg::*;

    logic [SPACE_W-3:0]   word_adr;
    logic                 access;
    logic                 wr_stat;
    logic [NUM_LINKS-1:0] timeout_q;
    logic [NUM_LINKS-1:0] invalid_q;

    assign word_adr = adr_i[SPACE_W-1:2];
    // Strobe is held until ack, so only its first cycle counts
    assign access   = stb_i && !ack_o;
    assign wr_stat  = access && we_i && (word_adr == REG_BRIDGE_STAT);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            ack_o         <= 1'b0;
            bridge_link_o <= '0;
            bridge_kind_o <= BRIDGE_NONE;
            timeout_q     <= '0;
            invalid_q     <= '0;
        end else begin
            ack_o <= access;
            if (access && we_i && word_adr == REG_BRIDGE_CTRL) begin
                bridge_link_o <= dat_i[3:2];
                bridge_kind_o <= bridge_kind_t'(dat_i[1:0]);
            end
            // New events win over a clear in the same cycle
            timeout_q <= (timeout_q & ~(wr_stat ? dat_i[3:0] : 4'h0)) | timeout_i;
            invalid_q <= (invalid_q & ~(wr_stat ? dat_i[7:4] : 4'h0)) | invalid_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (access) begin
            case (word_adr)
                REG_IDENT:       dat_o <= IDENT_WORD;
                REG_DATEVERSION: dat_o <= DATEVERSION_WORD;
                REG_BRIDGE_CTRL: dat_o <= {28'h0, bridge_link_o, bridge_kind_o};
                REG_BRIDGE_STAT: dat_o <= {24'h0, invalid_q, timeout_q};
                default:         dat_o <= '0;
            endcase
        end
    end

    a_ack_after_stb : assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        ack_o |-> $past(stb_i));

endmodule

`default_nettype wire

/* crate_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module crate_bridge (
    input  wire                              ps_clk,
    input  wire                              rst_n_i,
    input  wire                              stb_i,
    input  wire                              we_i,
    input  wire [turf_pkg::CRATE_ADDR_W-1:0] adr_i,
    input  wire [turf_pkg::DATA_W-1:0]       dat_i,
    output logic                             ack_o,
    output logic [turf_pkg::DATA_W-1:0]      dat_o,
    input  wire [turf_pkg::LINK_W-1:0]       bridge_link_i,
    input  turf_pkg::bridge_kind_t           bridge_kind_i,
    input  wire [turf_pkg::NUM_LINKS-1:0]    link_up_i,
    output logic [turf_pkg::NUM_LINKS-1:0]   timeout_o,
    output logic [turf_pkg::NUM_LINKS-1:0]   invalid_o,
    output logic                             cmd_tvalid_o,
    input  wire                              cmd_tready_i,
    output logic [turf_pkg::DATA_W-1:0]      cmd_tdata_o,
    output logic [turf_pkg::LINK_W-1:0]      cmd_tdest_o,
    output logic                             cmd_tlast_o,
    input  wire                              resp_tvalid_i,
    output logic                             resp_tready_o,
    input  wire [turf_pkg::DATA_W-1:0]       resp_tdata_i,
    input  wire [turf_pkg::LINK_W-1:0]       resp_tuser_i
);

    import turf_pkg::*;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_ADDR,
        BR_DATA,
        BR_RESP,
        BR_ACK
    } br_state_t;

    br_state_t state;
    logic [$clog2(BRIDGE_TIMEOUT_CYCLES)-1:0] tmo_cnt;
    logic                    we_q;
    logic [CRATE_ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0]       wdat_q;
    logic [LINK_W-1:0]       link_q;
    logic [DATA_W-1:0]       addr_beat;
    logic                    resp_hit;

    always_comb begin
        addr_beat                     = '0;
        addr_beat[CMD_WE_BIT]         = we_q;
        addr_beat[CRATE_ADDR_W-1:0]   = adr_q;
    end

    assign resp_hit = resp_tvalid_i && (resp_tuser_i == link_q);

    ////////////////////////////////////////////////////////////////////////////
    // Access sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state     <= BR_IDLE;
            tmo_cnt   <= '0;
            timeout_o <= '0;
            invalid_o <= '0;
        end else begin
            timeout_o <= '0;
            invalid_o <= '0;
            case (state)
                BR_IDLE: begin
                    if (stb_i) begin
                        if (bridge_kind_i == BRIDGE_NONE) begin
                            state <= BR_ACK;
                        end else if (bridge_kind_i == BRIDGE_AURORA &&
                                     link_up_i[bridge_link_i]) begin
                            state <= BR_ADDR;
                        end else begin
                            invalid_o[bridge_link_i] <= 1'b1;
                            state <= BR_ACK;
                        end
                    end
                end
                BR_ADDR: begin
                    tmo_cnt <= '0;
                    if (cmd_tready_i) begin
                        state <= we_q ? BR_DATA : BR_RESP;
                    end
                end
                BR_DATA: begin
                    tmo_cnt <= '0;
                    if (cmd_tready_i) begin
                        state <= BR_RESP;
                    end
                end
                BR_RESP: begin
                    tmo_cnt <= tmo_cnt + 1'b1;
                    if (resp_hit) begin
                        state <= BR_ACK;
                    end else if (tmo_cnt == BRIDGE_TIMEOUT_CYCLES - 1) begin
                        timeout_o[link_q] <= 1'b1;
                        state <= BR_ACK;
                    end
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // Request latch and read data
    always_ff @(posedge ps_clk) begin
        if (state == BR_IDLE && stb_i) begin
            we_q   <= we_i;
            adr_q  <= adr_i;
            wdat_q <= dat_i;
            link_q <= bridge_link_i;
            if (bridge_kind_i == BRIDGE_NONE) begin
                dat_o <= '0;
            end else begin
                dat_o <= BRIDGE_ERR_DATA;
            end
        end else if (state == BR_RESP) begin
            if (resp_hit) begin
                dat_o <= resp_tdata_i;
            end else begin
                dat_o <= BRIDGE_ERR_DATA;
            end
        end
    end

    assign ack_o         = (state == BR_ACK);
    assign cmd_tvalid_o  = (state == BR_ADDR) || (state == BR_DATA);
    assign cmd_tdata_o   = (state == BR_DATA) ? wdat_q : addr_beat;
    assign cmd_tlast_o   = (state == BR_DATA) || !we_q;
    assign cmd_tdest_o   = link_q;
    assign resp_tready_o = 1'b1;

    a_cmd_stable : assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        (cmd_tvalid_o && !cmd_tready_i) |=>
            (cmd_tvalid_o && $stable(cmd_tdata_o) && $stable(cmd_tlast_o)));

endmodule

`default_nettype wire

/* uart_baud_ticks.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_baud_ticks (
    input  wire  ps_clk,
    input  wire  rst_n_i,
    output logic hsk_tick_o,
    output logic gps_tick_o
);

    import turf_pkg::*;

    // One extra bit on each accumulator holds the carry
    logic [HSK_ACC_W:0] hsk_acc;
    logic [GPS_ACC_W:0] gps_acc;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            hsk_acc <= '0;
            gps_acc <= '0;
        end else begin
            hsk_acc <= {1'b0, hsk_acc[HSK_ACC_W-1:0]} + {1'b0, HSK_ADD};
            gps_acc <= {1'b0, gps_acc[GPS_ACC_W-1:0]} + {1'b0, GPS_ADD};
        end
    end

    assign hsk_tick_o = hsk_acc[HSK_ACC_W];
    assign gps_tick_o = gps_acc[GPS_ACC_W];

endmodule

`default_nettype wire

/* turf_regs_top.sv */
`timescale 1ns/1ns
`default_nettype none

module turf_regs_top (
    input  wire                            ps_clk,
    input  wire                            rst_n_i,
    input  wire                            wb_cyc_i,
    input  wire                            wb_stb_i,
    input  wire                            wb_we_i,
    input  wire [turf_pkg::ADDR_W-1:0]     wb_adr_i,
    input  wire [turf_pkg::DATA_W-1:0]     wb_dat_i,
    output logic                           wb_ack_o,
    output logic [turf_pkg::DATA_W-1:0]    wb_dat_o,
    input  wire [turf_pkg::NUM_LINKS-1:0]  link_up_i,
    output logic                           cmd_tvalid_o,
    input  wire                            cmd_tready_i,
    output logic [turf_pkg::DATA_W-1:0]    cmd_tdata_o,
    output logic [turf_pkg::LINK_W-1:0]    cmd_tdest_o,
    output logic                           cmd_tlast_o,
    input  wire                            resp_tvalid_i,
    output logic                           resp_tready_o,
    input  wire [turf_pkg::DATA_W-1:0]     resp_tdata_i,
    input  wire [turf_pkg::LINK_W-1:0]     resp_tuser_i,
    output logic                           hsk_tick_o,
    output logic                           gps_tick_o
);

    import turf_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Register bus fabric
    ////////////////////////////////////////////////////////////////////////////

    logic                    id_stb;
    logic                    crate_stb;
    logic                    slv_we;
    logic [CRATE_ADDR_W-1:0] slv_adr;
    logic [DATA_W-1:0]       slv_dat;
    logic                    id_ack;
    logic                    crate_ack;
    logic [DATA_W-1:0]       id_dat;
    logic [DATA_W-1:0]       crate_dat;

    // Bridge selection and status between ID space and bridge
    logic [LINK_W-1:0]       bridge_link;
    bridge_kind_t            bridge_kind;
    logic [NUM_LINKS-1:0]    bridge_timeout;
    logic [NUM_LINKS-1:0]    bridge_invalid;

    turf_intercon i_intercon (
        .ps_clk      (ps_clk),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .id_stb_o    (id_stb),
        .crate_stb_o (crate_stb),
        .slv_we_o    (slv_we),
        .slv_adr_o   (slv_adr),
        .slv_dat_o   (slv_dat),
        .id_ack_i    (id_ack),
        .crate_ack_i (crate_ack),
        .id_dat_i    (id_dat),
        .crate_dat_i (crate_dat)
    );

    turf_id_ctrl i_id_ctrl (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .stb_i         (id_stb),
        .we_i          (slv_we),
        .adr_i         (slv_adr[SPACE_W-1:0]),
        .dat_i         (slv_dat),
        .ack_o         (id_ack),
        .dat_o         (id_dat),
        .bridge_link_o (bridge_link),
        .bridge_kind_o (bridge_kind),
        .timeout_i     (bridge_timeout),
        .invalid_i     (bridge_invalid)
    );

    crate_bridge i_bridge (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .stb_i         (crate_stb),
        .we_i          (slv_we),
        .adr_i         (slv_adr),
        .dat_i         (slv_dat),
        .ack_o         (crate_ack),
        .dat_o         (crate_dat),
        .bridge_link_i (bridge_link),
        .bridge_kind_i (bridge_kind),
        .link_up_i     (link_up_i),
        .timeout_o     (bridge_timeout),
        .invalid_o     (bridge_invalid),
        .cmd_tvalid_o  (cmd_tvalid_o),
        .cmd_tready_i  (cmd_tready_i),
        .cmd_tdata_o   (cmd_tdata_o),
        .cmd_tdest_o   (cmd_tdest_o),
        .cmd_tlast_o   (cmd_tlast_o),
        .resp_tvalid_i (resp_tvalid_i),
        .resp_tready_o (resp_tready_o),
        .resp_tdata_i  (resp_tdata_i),
        .resp_tuser_i  (resp_tuser_i)
    );

    // Serial debug sample ticks
    uart_baud_ticks i_baud (
        .ps_clk     (ps_clk),
        .rst_n_i    (rst_n_i),
        .hsk_tick_o (hsk_tick_o),
        .gps_tick_o (gps_tick_o)
    );

endmodule

`default_nettype wire

/* tb_turf_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_turf_regs;

    import turf_pkg::*;

    localparam int NUM_OPS     = 29;
    localparam int TICK_WINDOW = 4096;
    localparam int ACK_LIMIT   = 2 * BRIDGE_TIMEOUT_CYCLES;
    localparam int RUN_LIMIT   = NUM_OPS * 2 * BRIDGE_TIMEOUT_CYCLES + TICK_WINDOW + 64;

    // One bus access with its link conditions and expected read data
    typedef struct packed {
        logic        is_write;
        logic [27:0] addr;
        logic [31:0] wdata;
        logic [3:0]  link_up;
        logic        silent;
        logic [31:0] rd_exp;
    } op_t;

    logic        ps_clk;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [27:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    logic [3:0]  link_up_i;
    logic        cmd_tvalid_o;
    logic        cmd_tready_i;
    logic [31:0] cmd_tdata_o;
    logic [1:0]  cmd_tdest_o;
    logic        cmd_tlast_o;
    logic        resp_tvalid_i;
    logic        resp_tready_o;
    logic [31:0] resp_tdata_i;
    logic [1:0]  resp_tuser_i;
    logic        hsk_tick_o;
    logic        gps_tick_o;

    op_t         ops [NUM_OPS];
    int          n_ops = 0;
    logic        silent_now;
    logic [1:0]  exp_link;
    logic [1:0]  exp_kind;

    // Link model state with one {tdest, tlast, tdata} entry per accepted beat
    logic [34:0] cmd_log [$];
    logic [31:0] rng_state = 32'hf97d_3334;
    int          reply_cnt = 0;
    logic        in_cmd = 1'b0;
    logic [31:0] model_addr_beat = '0;
    logic [1:0]  reply_dest = '0;
    logic [31:0] reply_data = '0;

    turf_regs_top i_dut (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .link_up_i     (link_up_i),
        .cmd_tvalid_o  (cmd_tvalid_o),
        .cmd_tready_i  (cmd_tready_i),
        .cmd_tdata_o   (cmd_tdata_o),
        .cmd_tdest_o   (cmd_tdest_o),
        .cmd_tlast_o   (cmd_tlast_o),
        .resp_tvalid_i (resp_tvalid_i),
        .resp_tready_o (resp_tready_o),
        .resp_tdata_i  (resp_tdata_i),
        .resp_tuser_i  (resp_tuser_i),
        .hsk_tick_o    (hsk_tick_o),
        .gps_tick_o    (gps_tick_o)
    );

    initial begin
        ps_clk = 1'b0;
        forever #2 ps_clk = ~ps_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s = %h, expected %h",
                                $time, name, got, expected));
        end
    endtask

    task automatic add_op(input logic is_write, input logic [27:0] addr,
                          input logic [31:0] wdata, input logic [3:0] link_up,
                          input logic silent, input logic [31:0] rd_exp);
        if (n_ops >= NUM_OPS) begin
            abort_run("operation table holds more entries than NUM_OPS");
        end
        ops[n_ops] = {is_write, addr, wdata, link_up, silent, rd_exp};
        n_ops++;
    endtask

    task automatic load_table;
        // ID and empty spaces
        add_op(1'b0, 28'h000_0000, 32'h0, 4'hF, 1'b0, 32'h5455_5246);
        add_op(1'b0, 28'h000_0004, 32'h0, 4'hF, 1'b0, DATEVERSION_WORD);
        add_op(1'b0, 28'h000_8000, 32'h0, 4'hF, 1'b0, 32'h0);
        add_op(1'b1, 28'h000_8008, 32'h1234_5678, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h001_0008, 32'h0, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h000_0008, 32'h0, 4'hF, 1'b0, 32'h0);
        // Bridge off, then link 2 on Aurora
        add_op(1'b0, 28'h800_0100, 32'h0, 4'hF, 1'b0, 32'h0);
        add_op(1'b1, 28'h000_0008, 32'h0000_0009, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h000_0008, 32'h0, 4'hF, 1'b0, 32'h0000_0009);
        add_op(1'b0, 28'h800_1234, 32'h0, 4'hF, 1'b0, 32'h5A5A_1234);
        add_op(1'b1, 28'h800_0040, 32'hCAFE_F00D, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'hFFF_FFFC, 32'h0, 4'hF, 1'b0, 32'h5DA5_FFFC);
        // Link 2 down
        add_op(1'b0, 28'h800_0200, 32'h0, 4'b1011, 1'b0, BRIDGE_ERR_DATA);
        add_op(1'b0, 28'h000_000C, 32'h0, 4'hF, 1'b0, 32'h0000_0040);
        add_op(1'b1, 28'h000_000C, 32'h0000_0040, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h000_000C, 32'h0, 4'hF, 1'b0, 32'h0);
        // Reserved kind on link 1
        add_op(1'b1, 28'h000_0008, 32'h0000_0006, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h800_0300, 32'h0, 4'hF, 1'b0, BRIDGE_ERR_DATA);
        add_op(1'b0, 28'h000_000C, 32'h0, 4'hF, 1'b0, 32'h0000_0020);
        add_op(1'b1, 28'h000_000C, 32'h0000_0020, 4'hF, 1'b0, 32'h0);
        // Silent link 3 runs into the timeout
        add_op(1'b1, 28'h000_0008, 32'h0000_000D, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h800_0400, 32'h0, 4'hF, 1'b1, BRIDGE_ERR_DATA);
        add_op(1'b0, 28'h000_000C, 32'h0, 4'hF, 1'b0, 32'h0000_0008);
        add_op(1'b1, 28'h000_000C, 32'h0000_0008, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h000_000C, 32'h0, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h800_0444, 32'h0, 4'hF, 1'b0, 32'h5A5A_0444);
        add_op(1'b1, 28'h800_0010, 32'h0BAD_F00D, 4'hF, 1'b0, 32'h0);
        add_op(1'b1, 28'h000_0008, 32'h0000_0000, 4'hF, 1'b0, 32'h0);
        add_op(1'b0, 28'h800_0600, 32'h0, 4'hF, 1'b0, 32'h0);
    endtask

    task automatic run_op(input int idx);
        op_t         op;
        int          cycles;
        int          base;
        int          exp_beats;
        logic [31:0] rdata;
        logic [34:0] beat;
        op = ops[idx];
        base = cmd_log.size();
        @(negedge ps_clk);
        link_up_i  = op.link_up;
        silent_now = op.silent;
        wb_cyc_i   = 1'b1;
        wb_stb_i   = 1'b1;
        wb_we_i    = op.is_write;
        wb_adr_i   = op.addr;
        wb_dat_i   = op.wdata;
        cycles = 0;
        do begin
            @(negedge ps_clk);
            cycles++;
            if (cycles > ACK_LIMIT) begin
                abort_run($sformatf("op %0d got no bus ack within %0d cycles", idx, ACK_LIMIT));
            end
        end while (!wb_ack_o);
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;

        if (!op.is_write) begin
            check_value($sformatf("op %0d wb_dat_o", idx), rdata, op.rd_exp);
        end
        // ID space takes 3 cycles, empty space 2
        if (!op.addr[27]) begin
            check_value($sformatf("op %0d ack latency", idx), cycles,
                        (op.addr[16:15] == 2'b00) ? 3 : 2);
        end

        exp_beats = 0;
        if (op.addr[27] && exp_kind == BRIDGE_AURORA && op.link_up[exp_link]) begin
            exp_beats = op.is_write ? 2 : 1;
        end
        check_value($sformatf("op %0d command beat count", idx),
                    32'(cmd_log.size() - base), exp_beats);
        if (exp_beats > 0) begin
            beat = cmd_log[base];
            check_value("cmd_tdest_o", {30'b0, beat[34:33]}, {30'b0, exp_link});
            check_value("cmd_tdata_o", beat[31:0], {op.is_write, 4'b0, op.addr[26:0]});
            check_value("cmd_tlast_o", {31'b0, beat[32]}, {31'b0, !op.is_write});
        end
        if (exp_beats == 2) begin
            beat = cmd_log[base + 1];
            check_value("cmd_tdest_o", {30'b0, beat[34:33]}, {30'b0, exp_link});
            check_value("cmd_tdata_o", beat[31:0], op.wdata);
            check_value("cmd_tlast_o", {31'b0, beat[32]}, 32'd1);
        end

        // Track the bridge control register for the beat checks
        if (op.is_write && !op.addr[27] && op.addr[16:15] == 2'b00 &&
            op.addr[14:2] == 13'd2) begin
            exp_link = op.wdata[3:2];
            exp_kind = op.wdata[1:0];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Link model
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        cmd_tready_i  = 1'b0;
        resp_tvalid_i = 1'b0;
        resp_tdata_i  = '0;
        resp_tuser_i  = '0;
        forever begin
            @(negedge ps_clk);
            resp_tvalid_i = 1'b0;
            if (reply_cnt > 0) begin
                reply_cnt = reply_cnt - 1;
                if (reply_cnt == 1) begin
                    // Beat tagged for another link that the bridge must drop
                    resp_tvalid_i = 1'b1;
                    resp_tuser_i  = reply_dest ^ 2'b01;
                    resp_tdata_i  = 32'hDEAD_BEEF;
                end else if (reply_cnt == 0 && !silent_now) begin
                    resp_tvalid_i = 1'b1;
                    resp_tuser_i  = reply_dest;
                    resp_tdata_i  = reply_data;
                end
            end
            rng_state    = next_random(rng_state);
            cmd_tready_i = (rng_state[1:0] != 2'b00);
            // Transfer completes on the coming rising edge
            if (cmd_tvalid_o && cmd_tready_i) begin
                cmd_log.push_back({cmd_tdest_o, cmd_tlast_o, cmd_tdata_o});
                if (!in_cmd) begin
                    model_addr_beat = cmd_tdata_o;
                end
                in_cmd = !cmd_tlast_o;
                if (cmd_tlast_o) begin
                    reply_dest = cmd_tdest_o;
                    reply_data = model_addr_beat[31] ? 32'h0 :
                                 ({5'b0, model_addr_beat[26:0]} ^ 32'h5A5A_0000);
                    reply_cnt  = 4 + int'(rng_state[3:2]);
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (RUN_LIMIT) @(posedge ps_clk);
        abort_run("watchdog expired before the test sequence finished");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int hsk_count;
        int gps_count;
        rst_n_i    = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        link_up_i  = 4'hF;
        silent_now = 1'b0;
        exp_link   = 2'd0;
        exp_kind   = BRIDGE_NONE;
        hsk_count  = 0;
        gps_count  = 0;

        load_table();
        if (n_ops != NUM_OPS) begin
            abort_run("operation table is shorter than NUM_OPS");
        end

        repeat (4) @(negedge ps_clk);
        check_value("wb_ack_o", {31'b0, wb_ack_o}, 32'd0);
        check_value("cmd_tvalid_o", {31'b0, cmd_tvalid_o}, 32'd0);
        check_value("resp_tready_o", {31'b0, resp_tready_o}, 32'd1);
        check_value("hsk_tick_o", {31'b0, hsk_tick_o}, 32'd0);
        check_value("gps_tick_o", {31'b0, gps_tick_o}, 32'd0);
        rst_n_i = 1'b1;

        for (int i = 0; i < NUM_OPS; i++) begin
            run_op(i);
        end

        // 82/1024 and 25/4096 of the clock rate
        repeat (TICK_WINDOW) begin
            @(negedge ps_clk);
            if (hsk_tick_o) hsk_count++;
            if (gps_tick_o) gps_count++;
        end
        check_value("hsk_tick_o count", hsk_count, 32'd328);
        check_value("gps_tick_o count", gps_count, 32'd25);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
turf_pkg.sv
turf_intercon.sv
turf_id_ctrl.sv
crate_bridge.sv
uart_baud_ticks.sv
turf_regs_top.sv
tb_turf_regs.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_turf_regs
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Simulation passes only when the log holds the pass line
run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
